/* bench/core_vectors.txt */
# P <byte address hex> <instruction hex>, T <test name>
# R <rd decimal> <value hex>, expected retires in program order
T alu_imm
P 00000000 00500093  # addi x1, x0, 5
P 00000004 ffd00113  # addi x2, x0, -3
P 00000008 00112193  # slti x3, x2, 1
P 0000000c 00113213  # sltiu x4, x2, 1
P 00000010 00f0c293  # xori x5, x1, 0xf
P 00000014 0300e313  # ori x6, x1, 0x30
P 00000018 0ff17393  # andi x7, x2, 0xff
P 0000001c 00409413  # slli x8, x1, 4
P 00000020 01c15493  # srli x9, x2, 28
P 00000024 40115513  # srai x10, x2, 1
R 1 00000005
R 2 fffffffd
R 3 00000001
R 4 00000000
R 5 0000000a
R 6 00000035
R 7 000000fd
R 8 00000050
R 9 0000000f
R 10 fffffffe
T alu_reg
P 00000028 002085b3  # add x11, x1, x2
P 0000002c 40208633  # sub x12, x1, x2
P 00000030 001096b3  # sll x13, x1, x1
P 00000034 00112733  # slt x14, x2, x1
P 00000038 001137b3  # sltu x15, x2, x1
P 0000003c 0060c833  # xor x16, x1, x6
P 00000040 001158b3  # srl x17, x2, x1
P 00000044 40115933  # sra x18, x2, x1
P 00000048 0080e9b3  # or x19, x1, x8
P 0000004c 00737a33  # and x20, x6, x7
P 00000050 12345ab7  # lui x21, 0x12345
R 11 00000002
R 12 00000008
R 13 000000a0
R 14 00000001
R 15 00000000
R 16 00000030
R 17 07ffffff
R 18 ffffffff
R 19 00000055
R 20 00000035
R 21 12345000
T forwarding
P 00000054 00700b13  # addi x22, x0, 7
P 00000058 001b0b93  # addi x23, x22, 1
P 0000005c 017b0c33  # add x24, x22, x23
P 00000060 018b0cb3  # add x25, x22, x24
P 00000064 019b8d33  # add x26, x23, x25
R 22 00000007
R 23 00000008
R 24 0000000f
R 25 00000016
R 26 0000001e
T x0_writes
P 00000068 06300013  # addi x0, x0, 99
P 0000006c 00100db3  # add x27, x0, x1
R 27 00000005
T branches
P 00000070 00108463  # beq x1, x1, +8 taken
P 00000074 00100e13  # addi x28, x0, 1 shadow
P 00000078 00109463  # bne x1, x1, +8 not taken
P 0000007c 00200e13  # addi x28, x0, 2
P 00000080 00209463  # bne x1, x2, +8 taken
P 00000084 00300e13  # addi x28, x0, 3 shadow
P 00000088 00114463  # blt x2, x1, +8 taken
P 0000008c 00400e13  # addi x28, x0, 4 shadow
P 00000090 00115463  # bge x2, x1, +8 not taken
P 00000094 00500e93  # addi x29, x0, 5
P 00000098 0020d463  # bge x1, x2, +8 taken
P 0000009c 00600e93  # addi x29, x0, 6 shadow
P 000000a0 0020e463  # bltu x1, x2, +8 taken
P 000000a4 00700e93  # addi x29, x0, 7 shadow
P 000000a8 00116463  # bltu x2, x1, +8 not taken
P 000000ac 00800f13  # addi x30, x0, 8
P 000000b0 00117463  # bgeu x2, x1, +8 taken
P 000000b4 00900f13  # addi x30, x0, 9 shadow
P 000000b8 0020f463  # bgeu x1, x2, +8 not taken
P 000000bc 00a00f93  # addi x31, x0, 10
P 000000c0 005e0e13  # addi x28, x28, 5
P 000000c4 016e0463  # beq x28, x22, +8 taken on a forwarded value
P 000000c8 00b00f93  # addi x31, x0, 11 shadow
P 000000cc 00000063  # beq x0, x0, 0 branch to self
R 28 00000002
R 29 00000005
R 30 00000008
R 31 0000000a
R 28 00000007

/* sim.f */
+incdir+logic
logic/core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/writeback_unit.sv
logic/core_top.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: rv32i_core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/register_file.sv
      - logic/execute_unit.sv
      - logic/writeback_unit.sv
      - logic/core_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/core_tb.sv

/* bench/core_tb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb import core_pkg::*; ();

  localparam int MEM_WORDS      = 256;
  localparam int READ_TIMEOUT   = 50;
  localparam int RETIRE_TIMEOUT = 3000;
  localparam int QUIET_CYCLES   = 20;

  logic                      clk;
  logic                      reset;
  logic                      cyc;
  logic                      stb;
  logic [`CORE_ADR_BITS-1:0] adr;
  word_t                     dat;
  logic                      ack;
  retire_t                   retire;
  logic                      retire_valid;

  word_t                     imem [0:MEM_WORDS-1];
  retire_t                   exp_q [$];
  logic [8*24-1:0]           exp_name_q [$];
  logic [7:0]                lfsr_q;
  logic                      read_open;
  logic [`CORE_ADR_BITS-1:0] read_adr;
  int                        wait_left;

  core_top core_i (
    .clk_i          (clk),
    .reset_i        (reset),
    .cyc_o          (cyc),
    .stb_o          (stb),
    .adr_o          (adr),
    .dat_i          (dat),
    .ack_i          (ack),
    .retire_o       (retire),
    .retire_valid_o (retire_valid)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // opcode field zero so stray fetches decode as no-ops
  function automatic word_t fill_word(input logic [`CORE_ADR_BITS-1:0] a);
    return {a[24:0] ^ {20'h0, a[29:25]}, 7'b0000000};
  endfunction

  function automatic word_t mem_read(input logic [`CORE_ADR_BITS-1:0] a);
    if (a < MEM_WORDS) begin
      return imem[a];
    end
    return fill_word(a);
  endfunction

  // two lfsr bits give 0 to 3 wait cycles
  task automatic next_delay(output int delay);
    logic b0;
    logic b1;
    lfsr_q = lfsr_step(lfsr_q);
    b0 = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    b1 = lfsr_q[0];
    delay = {b1, b0};
  endtask

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_retire(input logic [8*24-1:0] test_name, input retire_t expected,
                              input retire_t actual);
    if (actual !== expected) begin
      $display("mismatch in %0s: expected rd=%0d data=%h, actual rd=%0d data=%h",
               test_name, expected.rd, expected.data, actual.rd, actual.data);
      fail_run();
    end
  endtask

  task automatic check_word(input logic [8*24-1:0] test_name, input word_t expected,
                            input word_t actual);
    if (actual !== expected) begin
      $display("mismatch in %0s: expected %h, actual %h", test_name, expected, actual);
      fail_run();
    end
  endtask

  // P addr insn, T name, R rd value
  task automatic load_vectors();
    int                        fd;
    int                        code;
    int                        rd;
    logic [8*128-1:0]          line;
    logic [8*8-1:0]            tag;
    logic [8*24-1:0]           name;
    logic [`CORE_ADR_BITS-1:0] a;
    word_t                     addr;
    word_t                     insn;
    word_t                     value;
    retire_t                   item;
    name = "none";
    for (int i = 0; i < MEM_WORDS; i++) begin
      a = i;
      imem[i] = fill_word(a);
    end
    fd = $fopen("bench/core_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file bench/core_vectors.txt");
      fail_run();
    end
    code = $fgets(line, fd);
    while (code != 0) begin
      tag = '0;
      code = $sscanf(line, "%s", tag);
      if (code < 1 || tag == "#") begin
        // blank or comment line
      end else if (tag == "P") begin
        code = $sscanf(line, "%s %h %h", tag, addr, insn);
        if (addr[31:2] >= MEM_WORDS) begin
          $display("program word at %h lies outside the memory model", addr);
          fail_run();
        end
        imem[addr[31:2]] = insn;
      end else if (tag == "T") begin
        code = $sscanf(line, "%s %s", tag, name);
      end else if (tag == "R") begin
        code = $sscanf(line, "%s %d %h", tag, rd, value);
        item.rd   = rd[`CORE_REG_BITS-1:0];
        item.data = value;
        exp_q.push_back(item);
        exp_name_q.push_back(name);
      end else begin
        $display("unknown line in the vector file: %0s", line);
        fail_run();
      end
      code = $fgets(line, fd);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // clock, memory model, retire monitor
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // wishbone slave that acks after a random number of cycles
  always @(posedge clk) begin
    #2;
    if (reset) begin
      ack       = 1'b0;
      read_open = 1'b0;
    end else if (cyc !== stb) begin
      $display("cyc and stb of the fetch bus disagree");
      fail_run();
    end else if (ack) begin
      ack       = 1'b0;
      read_open = 1'b0;
    end else if (cyc && stb) begin
      if (!read_open) begin
        read_open = 1'b1;
        read_adr  = adr;
        next_delay(wait_left);
      end else if (adr !== read_adr) begin
        $display("the fetch address changed while a bus read was open");
        fail_run();
      end
      if (wait_left == 0) begin
        ack = 1'b1;
        dat = mem_read(adr);
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  always @(negedge clk) begin
    if (reset && (retire_valid === 1'b1 || cyc === 1'b1)) begin
      $display("the core retired or read the bus while in reset");
      fail_run();
    end else if (!reset && retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected retire of rd=%0d data=%h", retire.rd, retire.data);
        fail_run();
      end else begin
        check_retire(exp_name_q[0], exp_q[0], retire);
        exp_q.pop_front();
        exp_name_q.pop_front();
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int cycles;
    reset     = 1'b1;
    ack       = 1'b0;
    dat       = '0;
    lfsr_q    = 8'd39;
    read_open = 1'b0;
    read_adr  = '0;
    wait_left = 0;
    load_vectors();
    repeat (8) @(posedge clk);
    #2 reset = 1'b0;

    // first read must come from the reset pc
    cycles = 0;
    @(negedge clk);
    while (!cyc) begin
      if (cycles == READ_TIMEOUT) begin
        $display("timed out waiting for the first bus read after reset");
        fail_run();
      end
      cycles = cycles + 1;
      @(negedge clk);
    end
    check_word("reset_fetch", `CORE_RESET_PC, {adr, 2'b00});

    cycles = 0;
    while (exp_q.size() != 0) begin
      if (cycles == RETIRE_TIMEOUT) begin
        $display("timed out with %0d expected retires still missing", exp_q.size());
        fail_run();
      end
      cycles = cycles + 1;
      @(negedge clk);
    end

    // the program now spins on its branch to self
    repeat (QUIET_CYCLES) @(negedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* logic/core_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top import core_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  output logic                      cyc_o,
  output logic                      stb_o,
  output logic [`CORE_ADR_BITS-1:0] adr_o,
  input  word_t                     dat_i,
  input  logic                      ack_i,
  output retire_t                   retire_o,
  output logic                      retire_valid_o
);

  redirect_t redirect;
  fetch_t    fetch;
  decoded_t  decoded;
  exec_t     exec_s;
  exec_t     wb_s;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rf_we;
  reg_addr_t rf_rd;
  word_t     rf_data;

  //////////////////////////////////////////////////
  // front end
  //////////////////////////////////////////////////

  fetch_unit u_fetch (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .redirect_i (redirect),
    .cyc_o      (cyc_o),
    .stb_o      (stb_o),
    .adr_o      (adr_o),
    .dat_i      (dat_i),
    .ack_i      (ack_i),
    .fetch_o    (fetch)
  );

  decode_unit u_decode (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flush_i   (redirect.taken),
    .fetch_i   (fetch),
    .decoded_o (decoded)
  );

  // read in the execute cycle, indices come from the decode register
  register_file u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_i      (decoded.rs1),
    .rs2_i      (decoded.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_i       (rf_rd),
    .rd_data_i  (rf_data)
  );

  //////////////////////////////////////////////////
  // back end
  //////////////////////////////////////////////////

  execute_unit u_execute (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .flush_i    (redirect.taken),
    .decoded_i  (decoded),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .wb_i       (wb_s),
    .exec_o     (exec_s)
  );

  writeback_unit u_writeback (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .exec_i         (exec_s),
    .wb_o           (wb_s),
    .we_o           (rf_we),
    .rd_o           (rf_rd),
    .rd_data_o      (rf_data),
    .retire_o       (retire_o),
    .retire_valid_o (retire_valid_o),
    .redirect_o     (redirect)
  );

endmodule

/* logic/writeback_unit.sv */
`timescale 1ns/1ps

module writeback_unit import core_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  exec_t     exec_i,
  output exec_t     wb_o,
  output logic      we_o,
  output reg_addr_t rd_o,
  output word_t     rd_data_o,
  output retire_t   retire_o,
  output logic      retire_valid_o,
  output redirect_t redirect_o
);

  exec_t wb_q;
  logic  redirect_taken;
  logic  commit;

  // taken branch in the commit slot
  assign redirect_taken = wb_q.valid & wb_q.branch_taken;

  // the entry behind a taken branch is squashed
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_q.valid <= 1'b0;
    end else begin
      wb_q       <= exec_i;
      wb_q.valid <= exec_i.valid & ~redirect_taken;
    end
  end

  //////////////////////////////////////////////////
  // commit and retire
  //////////////////////////////////////////////////

  assign commit = wb_q.valid & (wb_q.rd != '0);

  assign we_o      = commit;
  assign rd_o      = wb_q.rd;
  assign rd_data_o = wb_q.result;

  assign retire_o.rd    = wb_q.rd;
  assign retire_o.data  = wb_q.result;
  assign retire_valid_o = commit;

  assign redirect_o.taken  = redirect_taken;
  assign redirect_o.target = wb_q.branch_target;

  assign wb_o = wb_q;

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import core_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  input  decoded_t decoded_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  input  exec_t    wb_i,
  output exec_t    exec_o
);

  word_t op_a;
  word_t op_b_reg;
  word_t op_b;
  word_t alu_result;
  logic  is_eq;
  logic  is_lt_u;
  logic  is_lt_s;
  logic  cond_met;
  exec_t exec_d;
  exec_t exec_q;

  // youngest producer first
  function automatic word_t forward_operand(
    input reg_addr_t rs,
    input word_t     rf_data,
    input exec_t     ex,
    input exec_t     wb
  );
    if (ex.valid && rs != '0 && ex.rd == rs) begin
      return ex.result;
    end else if (wb.valid && rs != '0 && wb.rd == rs) begin
      return wb.result;
    end
    return rf_data;
  endfunction

  //////////////////////////////////////////////////
  // operands
  //////////////////////////////////////////////////

  assign op_a     = forward_operand(decoded_i.rs1, rs1_data_i, exec_q, wb_i);
  assign op_b_reg = forward_operand(decoded_i.rs2, rs2_data_i, exec_q, wb_i);
  assign op_b     = decoded_i.use_imm ? decoded_i.imm : op_b_reg;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  always_comb begin
    case (decoded_i.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // compare flags for branches, always on the two registers
  assign is_eq   = (op_a == op_b_reg);
  assign is_lt_u = (op_a < op_b_reg);
  assign is_lt_s = ($signed(op_a) < $signed(op_b_reg));

  always_comb begin
    case (decoded_i.branch_cond)
      BEQ:     cond_met = is_eq;
      BNE:     cond_met = ~is_eq;
      BLT:     cond_met = is_lt_s;
      BGE:     cond_met = ~is_lt_s;
      BLTU:    cond_met = is_lt_u;
      BGEU:    cond_met = ~is_lt_u;
      default: cond_met = 1'b0;
    endcase
  end

  always_comb begin
    exec_d.valid         = decoded_i.valid & ~flush_i;
    exec_d.rd            = decoded_i.rd;
    exec_d.result        = alu_result;
    exec_d.branch_taken  = decoded_i.is_branch & cond_met;
    exec_d.branch_target = decoded_i.pc + decoded_i.imm;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exec_q.valid <= 1'b0;
    end else begin
      exec_q <= exec_d;
    end
  end

  assign exec_o = exec_q;

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module register_file import core_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  input  logic      we_i,
  input  reg_addr_t rd_i,
  input  word_t     rd_data_i
);

  logic [`CORE_REG_COUNT-1:0][`CORE_XLEN-1:0] regs_q;

  // x0 reads zero, a same-cycle write is bypassed
  function automatic word_t read_port(
    input reg_addr_t                                  rs,
    input logic                                       we,
    input reg_addr_t                                  rd,
    input word_t                                      wdata,
    input logic [`CORE_REG_COUNT-1:0][`CORE_XLEN-1:0] regs
  );
    if (rs == '0) begin
      return '0;
    end else if (we && rd == rs) begin
      return wdata;
    end
    return regs[rs];
  endfunction

  assign rs1_data_o = read_port(rs1_i, we_i, rd_i, rd_data_i, regs_q);
  assign rs2_data_o = read_port(rs2_i, we_i, rd_i, rd_data_i, regs_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_q <= '0;
    end else if (we_i && rd_i != '0) begin
      regs_q[rd_i] <= rd_data_i;
    end
  end

endmodule

/* logic/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit import core_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  input  fetch_t   fetch_i,
  output decoded_t decoded_o
);

  word_t     insn;
  opcode_e   opcode;
  logic [2:0] funct3;
  logic      funct7_alt;
  reg_addr_t rd_field;
  word_t     imm_i;
  word_t     imm_u;
  word_t     imm_b;
  decoded_t  dec_d;
  decoded_t  dec_q;

  // shared by OP and OP_IMM, alt selects SUB / SRA
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // field extraction
  //////////////////////////////////////////////////

  assign insn       = fetch_i.insn;
  assign funct3     = insn[14:12];
  assign funct7_alt = insn[30];
  assign rd_field   = insn[11:7];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    case (insn[6:0])
      OPC_OP:     opcode = OPC_OP;
      OPC_OP_IMM: opcode = OPC_OP_IMM;
      OPC_LUI:    opcode = OPC_LUI;
      OPC_BRANCH: opcode = OPC_BRANCH;
      default:    opcode = OPC_NOP;
    endcase
  end

  // anything not listed stays a no-op with rd = x0
  always_comb begin
    dec_d             = '0;
    dec_d.valid       = fetch_i.valid & ~flush_i;
    dec_d.pc          = fetch_i.pc;
    dec_d.rs1         = insn[19:15];
    dec_d.rs2         = insn[24:20];
    dec_d.alu_op      = ALU_ADD;
    dec_d.branch_cond = BEQ;
    case (opcode)
      OPC_OP: begin
        dec_d.alu_op = alu_from_funct(funct3, funct7_alt);
        dec_d.rd     = rd_field;
      end
      OPC_OP_IMM: begin
        // bit 30 is part of the immediate except for shifts
        dec_d.alu_op  = alu_from_funct(funct3, funct7_alt & (funct3 == 3'b101));
        dec_d.use_imm = 1'b1;
        dec_d.imm     = imm_i;
        dec_d.rd      = rd_field;
      end
      OPC_LUI: begin
        dec_d.alu_op  = ALU_PASS_B;
        dec_d.use_imm = 1'b1;
        dec_d.imm     = imm_u;
        dec_d.rd      = rd_field;
      end
      OPC_BRANCH: begin
        // funct3 010/011 are reserved
        if (funct3[2:1] != 2'b01) begin
          dec_d.is_branch   = 1'b1;
          dec_d.branch_cond = branch_cond_e'(funct3);
          dec_d.imm         = imm_b;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign decoded_o = dec_q;

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module fetch_unit import core_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  redirect_t                 redirect_i,
  output logic                      cyc_o,
  output logic                      stb_o,
  output logic [`CORE_ADR_BITS-1:0] adr_o,
  input  word_t                     dat_i,
  input  logic                      ack_i,
  output fetch_t                    fetch_o
);

  word_t                     pc_q;
  logic                      busy_q;
  logic                      discard_q;
  logic [`CORE_ADR_BITS-1:0] adr_q;
  fetch_t                    fetch_q;
  word_t                     issue_pc;
  logic                      take_insn;

  // a redirect wins over the sequential pc
  assign issue_pc = redirect_i.taken ? redirect_i.target : pc_q;

  // data is only kept if nothing redirected us since the read opened
  assign take_insn = busy_q & ack_i & ~discard_q & ~redirect_i.taken;

  //////////////////////////////////////////////////
  // wishbone read sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q      <= `CORE_RESET_PC;
      busy_q    <= 1'b0;
      discard_q <= 1'b0;
    end else if (!busy_q) begin
      // idle, open the next read
      busy_q <= 1'b1;
      adr_q  <= issue_pc[`CORE_XLEN-1:2];
      pc_q   <= issue_pc;
    end else if (ack_i) begin
      busy_q    <= 1'b0;
      discard_q <= 1'b0;
      pc_q      <= take_insn ? pc_q + `CORE_INSN_BYTES : issue_pc;
    end else if (redirect_i.taken) begin
      // read still in flight, drop its data when it lands
      pc_q      <= redirect_i.target;
      discard_q <= 1'b1;
    end
  end

  // fetch output register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_q.valid <= 1'b0;
    end else begin
      fetch_q.valid <= take_insn;
      if (take_insn) begin
        fetch_q.pc   <= pc_q;
        fetch_q.insn <= dat_i;
      end
    end
  end

  assign cyc_o   = busy_q;
  assign stb_o   = busy_q;
  assign adr_o   = adr_q;
  assign fetch_o = fetch_q;

endmodule

/* logic/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]     word_t;
  typedef logic [`CORE_REG_BITS-1:0] reg_addr_t;

  // major opcodes, values are insn[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_NOP    = 7'b0000000
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // branch conditions, encoded as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_cond_e;

  //////////////////////////////////////////////////
  // stage payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } fetch_t;

  typedef struct packed {
    logic         valid;
    word_t        pc;
    alu_op_e      alu_op;
    logic         use_imm;
    word_t        imm;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    logic         is_branch;
    branch_cond_e branch_cond;
  } decoded_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     result;
    logic      branch_taken;
    word_t     branch_target;
  } exec_t;

  typedef struct packed {
    reg_addr_t rd;
    word_t     data;
  } retire_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

/* logic/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define CORE_XLEN 32

// register file geometry
`define CORE_REG_BITS 5
`define CORE_REG_COUNT 32

// wishbone word address, byte address without the low two bits
`define CORE_ADR_BITS 30

// first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// pc step per instruction
`define CORE_INSN_BYTES 32'd4

`endif
